// File: source/rv_branch_predict.sv
// ====================
// Static branch predictor
// Backward branches and JAL predicted taken
// Target is PC plus the B or J offset
// ====================
`timescale 1ns/100ps
`default_nettype none

module rv_branch_predict (
	input wire rv_decode_pkg::instr_t instr_i,
	input wire rv_decode_pkg::addr_t pc_i,
	input wire jump_en_i,
	output logic jump_req_o,
	output rv_decode_pkg::addr_t jump_target_o
);
	import rv_decode_pkg::*;

	data_t imm_b;
	data_t imm_j;
	data_t jump_offs;

	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// JAL is 1101111, branches 1100011, so opcode bit 3 picks the format
	assign jump_offs = instr_i[3] ? imm_j : imm_b;
	assign jump_target_o = pc_i + jump_offs;

	// Sign bit set means a backward offset
	always_comb begin
		casez (instr_i)
			RV_BEQ, RV_BNE, RV_BLT, RV_BGE, RV_BLTU, RV_BGEU: begin
				jump_req_o = jump_en_i && instr_i[31];
			end
			RV_JAL: jump_req_o = jump_en_i;
			default: jump_req_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/rv_dctrl_if.sv
// ====================
// Decoded control bundle
// Decoder drives, D/X register samples
// ====================
`timescale 1ns/100ps
`default_nettype none

interface rv_dctrl_if;
	import rv_decode_pkg::*;

	regaddr_t rs1;
	regaddr_t rs2;
	regaddr_t rd;
	data_t imm;
	alusrc_a_t alusrc_a;
	alusrc_b_t alusrc_b;
	alu_op_t alu_op;
	mem_op_t mem_op;
	mul_op_t mul_op;
	bcond_t bcond;
	logic jump_is_regoffs;
	logic result_is_linkaddr;
	except_t except;
	// Word matched no legal opcode
	logic invalid;

	modport decoder (
		output rs1, rs2, rd, imm, alusrc_a, alusrc_b, alu_op, mem_op, mul_op,
		bcond, jump_is_regoffs, result_is_linkaddr, except, invalid
	);

	modport pipe (
		input rs1, rs2, rd, imm, alusrc_a, alusrc_b, alu_op, mem_op, mul_op,
		bcond, jump_is_regoffs, result_is_linkaddr, except, invalid
	);

endinterface

`default_nettype wire

// File: source/rv_decode_ctrl.sv
// ====================
// Decode stage control
// Program counter, stall, CIR use and CIR lock
// Gates the jump request through jump enable
// ====================
`timescale 1ns/100ps
`default_nettype none

module rv_decode_ctrl #(
	parameter rv_decode_pkg::addr_t RESET_VECTOR = '0
) (
	input wire clk,
	input wire rst_n,
	input wire fd_cir_vld_i,
	input wire x_stall_i,
	input wire f_jump_rdy_i,
	input wire f_jump_now_i,
	input wire rv_decode_pkg::addr_t f_jump_target_i,
	input wire invalid_i,
	input wire jump_req_i,
	output rv_decode_pkg::addr_t pc_o,
	output rv_decode_pkg::addr_t pc_next_o,
	output logic jump_en_o,
	output logic d_stall_o,
	output logic df_cir_use_o,
	output logic df_cir_lock_o
);

	logic starved;
	logic lock_assert;
	logic lock_prev;

	// Nothing in the CIR
	assign starved = !fd_cir_vld_i;
	// Stall also while fetch cannot take our jump yet
	assign d_stall_o = x_stall_i || starved || (jump_req_i && !f_jump_rdy_i);
	assign df_cir_use_o = !starved && !d_stall_o;

	// A locked CIR holds a jump that already went out
	assign jump_en_o = !starved && !lock_prev && !invalid_i;

	// ====================
	// CIR lock
	// ====================
	// Jump accepted by fetch but X holds us
	// Lock keeps fetch from overwriting the CIR until the stall clears
	assign lock_assert = jump_req_i && f_jump_rdy_i && d_stall_o;
	assign df_cir_lock_o = (lock_prev && d_stall_o) || lock_assert;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_prev <= 1'b0;
		end else begin
			lock_prev <= df_cir_lock_o;
		end
	end

	// Program counter
	assign pc_next_o = pc_o + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= RESET_VECTOR;
		end else if ((f_jump_now_i && !lock_assert) || (lock_prev && !d_stall_o)) begin
			// Fetch jumped, or a held lock releases onto the jump target
			pc_o <= f_jump_target_i;
		end else if (!d_stall_o && !df_cir_lock_o) begin
			pc_o <= pc_next_o;
		end
	end

endmodule

`default_nettype wire

// File: source/rv_decode_pkg.sv
// ====================
// RV32 decode package
// Word and register index types, execute control encodings
// and the opcode match patterns for the decode stage
// ====================
`default_nettype none

package rv_decode_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] regaddr_t;

	// ALU operation, MULDIV hands the op to the M unit
	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_LT, ALUOP_LTU, ALUOP_AND, ALUOP_OR,
		ALUOP_XOR, ALUOP_SLL, ALUOP_SRL, ALUOP_SRA, ALUOP_MULDIV
	} alu_op_t;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_t;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_t;

	typedef enum logic [3:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU,
		MEMOP_LHU, MEMOP_SB, MEMOP_SH, MEMOP_SW
	} mem_op_t;

	// Order follows funct3 of the M opcodes
	typedef enum logic [2:0] {
		MULOP_MUL, MULOP_MULH, MULOP_MULHSU, MULOP_MULHU,
		MULOP_DIV, MULOP_DIVU, MULOP_REM, MULOP_REMU
	} mul_op_t;

	// Branch taken when the ALU result matches the condition
	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS} bcond_t;

	typedef enum logic [2:0] {
		EXCEPT_NONE, EXCEPT_ILLEGAL, EXCEPT_ECALL, EXCEPT_EBREAK, EXCEPT_MRET
	} except_t;

	// ====================
	// Opcode match patterns, ? bits are don't care in casez
	// ====================
	localparam instr_t
		RV_BEQ     = 32'b?????????????????000?????1100011,
		RV_BNE     = 32'b?????????????????001?????1100011,
		RV_BLT     = 32'b?????????????????100?????1100011,
		RV_BGE     = 32'b?????????????????101?????1100011,
		RV_BLTU    = 32'b?????????????????110?????1100011,
		RV_BGEU    = 32'b?????????????????111?????1100011,
		RV_JALR    = 32'b?????????????????000?????1100111,
		RV_JAL     = 32'b?????????????????????????1101111,
		RV_LUI     = 32'b?????????????????????????0110111,
		RV_AUIPC   = 32'b?????????????????????????0010111,
		RV_ADDI    = 32'b?????????????????000?????0010011,
		RV_SLLI    = 32'b0000000??????????001?????0010011,
		RV_SLTI    = 32'b?????????????????010?????0010011,
		RV_SLTIU   = 32'b?????????????????011?????0010011,
		RV_XORI    = 32'b?????????????????100?????0010011,
		RV_SRLI    = 32'b0000000??????????101?????0010011,
		RV_SRAI    = 32'b0100000??????????101?????0010011,
		RV_ORI     = 32'b?????????????????110?????0010011,
		RV_ANDI    = 32'b?????????????????111?????0010011,
		RV_ADD     = 32'b0000000??????????000?????0110011,
		RV_SUB     = 32'b0100000??????????000?????0110011,
		RV_SLL     = 32'b0000000??????????001?????0110011,
		RV_SLT     = 32'b0000000??????????010?????0110011,
		RV_SLTU    = 32'b0000000??????????011?????0110011,
		RV_XOR     = 32'b0000000??????????100?????0110011,
		RV_SRL     = 32'b0000000??????????101?????0110011,
		RV_SRA     = 32'b0100000??????????101?????0110011,
		RV_OR      = 32'b0000000??????????110?????0110011,
		RV_AND     = 32'b0000000??????????111?????0110011,
		RV_LB      = 32'b?????????????????000?????0000011,
		RV_LH      = 32'b?????????????????001?????0000011,
		RV_LW      = 32'b?????????????????010?????0000011,
		RV_LBU     = 32'b?????????????????100?????0000011,
		RV_LHU     = 32'b?????????????????101?????0000011,
		RV_SB      = 32'b?????????????????000?????0100011,
		RV_SH      = 32'b?????????????????001?????0100011,
		RV_SW      = 32'b?????????????????010?????0100011,
		RV_MUL     = 32'b0000001??????????000?????0110011,
		RV_MULH    = 32'b0000001??????????001?????0110011,
		RV_MULHSU  = 32'b0000001??????????010?????0110011,
		RV_MULHU   = 32'b0000001??????????011?????0110011,
		RV_DIV     = 32'b0000001??????????100?????0110011,
		RV_DIVU    = 32'b0000001??????????101?????0110011,
		RV_REM     = 32'b0000001??????????110?????0110011,
		RV_REMU    = 32'b0000001??????????111?????0110011,
		RV_FENCE   = 32'b?????????????????000?????0001111,
		RV_FENCE_I = 32'b?????????????????001?????0001111,
		RV_ECALL   = 32'b00000000000000000000000001110011,
		RV_EBREAK  = 32'b00000000000100000000000001110011,
		RV_MRET    = 32'b00110000001000000000000001110011;

endpackage

`default_nettype wire

// File: source/rv_decode_top.sv
// ====================
// RV32 decode stage
// Decoder, branch predictor, stage control and D/X register
// ====================
`timescale 1ns/100ps
`default_nettype none

module rv_decode_top #(
	parameter rv_decode_pkg::addr_t RESET_VECTOR = '0,
	parameter bit EXTENSION_M = 1'b1
) (
	input wire clk,
	input wire rst_n,
	// Fetch side CIR
	input wire rv_decode_pkg::instr_t fd_cir_i,
	input wire fd_cir_vld_i,
	output wire df_cir_use_o,
	output wire df_cir_lock_o,
	// Jump request and fetch response
	output wire d_jump_req_o,
	output wire rv_decode_pkg::addr_t d_jump_target_o,
	input wire f_jump_rdy_i,
	input wire f_jump_now_i,
	input wire rv_decode_pkg::addr_t f_jump_target_i,
	// Pipeline control
	output wire d_stall_o,
	input wire x_stall_i,
	input wire flush_d_x_i,
	// Register file read addresses, combinational
	output wire rv_decode_pkg::regaddr_t d_rs1_o,
	output wire rv_decode_pkg::regaddr_t d_rs2_o,
	// D/X register
	output wire rv_decode_pkg::regaddr_t dx_rs1_o,
	output wire rv_decode_pkg::regaddr_t dx_rs2_o,
	output wire rv_decode_pkg::regaddr_t dx_rd_o,
	output wire rv_decode_pkg::data_t dx_imm_o,
	output wire rv_decode_pkg::alusrc_a_t dx_alusrc_a_o,
	output wire rv_decode_pkg::alusrc_b_t dx_alusrc_b_o,
	output wire rv_decode_pkg::alu_op_t dx_aluop_o,
	output wire rv_decode_pkg::mem_op_t dx_memop_o,
	output wire rv_decode_pkg::mul_op_t dx_mulop_o,
	output wire rv_decode_pkg::bcond_t dx_branchcond_o,
	output wire dx_jump_is_regoffs_o,
	output wire dx_result_is_linkaddr_o,
	output wire rv_decode_pkg::except_t dx_except_o,
	output wire rv_decode_pkg::addr_t dx_jump_target_o,
	output wire rv_decode_pkg::addr_t dx_pc_o,
	output wire rv_decode_pkg::addr_t dx_mispredict_addr_o
);
	import rv_decode_pkg::*;

	addr_t pc;
	addr_t pc_next;
	logic jump_en;

	rv_dctrl_if dctrl ();

	// Same-named ports connect by .*
	rv_decode_ctrl #(
		.RESET_VECTOR(RESET_VECTOR)
	) rv_decode_ctrl_i (
		.*,
		.invalid_i(dctrl.invalid),
		.jump_req_i(d_jump_req_o),
		.pc_o(pc),
		.pc_next_o(pc_next),
		.jump_en_o(jump_en)
	);

	rv_instr_decoder #(
		.EXTENSION_M(EXTENSION_M)
	) rv_instr_decoder_i (
		.instr_i(fd_cir_i),
		.dctrl(dctrl)
	);

	rv_branch_predict rv_branch_predict_i (
		.instr_i(fd_cir_i),
		.pc_i(pc),
		.jump_en_i(jump_en),
		.jump_req_o(d_jump_req_o),
		.jump_target_o(d_jump_target_o)
	);

	rv_dx_regs #(
		.EXTENSION_M(EXTENSION_M)
	) rv_dx_regs_i (
		.*,
		.d_stall_i(d_stall_o),
		.pc_i(pc),
		.pc_next_i(pc_next),
		.jump_target_i(d_jump_target_o),
		.dctrl(dctrl)
	);

	// Register reads go out before the D/X edge
	assign d_rs1_o = dctrl.rs1;
	assign d_rs2_o = dctrl.rs2;

endmodule

`default_nettype wire

// File: source/rv_dx_regs.sv
// ====================
// D/X pipeline register
// Masks invalid instructions to an illegal exception
// Inserts a bubble on decode stall or flush, holds on X stall
// ====================
`timescale 1ns/100ps
`default_nettype none

module rv_dx_regs #(
	parameter bit EXTENSION_M = 1'b1
) (
	input wire clk,
	input wire rst_n,
	input wire x_stall_i,
	input wire flush_d_x_i,
	input wire d_stall_i,
	input wire f_jump_now_i,
	input wire rv_decode_pkg::addr_t f_jump_target_i,
	input wire rv_decode_pkg::addr_t pc_i,
	input wire rv_decode_pkg::addr_t pc_next_i,
	input wire rv_decode_pkg::addr_t jump_target_i,
	rv_dctrl_if.pipe dctrl,
	output rv_decode_pkg::regaddr_t dx_rs1_o,
	output rv_decode_pkg::regaddr_t dx_rs2_o,
	output rv_decode_pkg::regaddr_t dx_rd_o,
	output rv_decode_pkg::data_t dx_imm_o,
	output rv_decode_pkg::alusrc_a_t dx_alusrc_a_o,
	output rv_decode_pkg::alusrc_b_t dx_alusrc_b_o,
	output rv_decode_pkg::alu_op_t dx_aluop_o,
	output rv_decode_pkg::mem_op_t dx_memop_o,
	output rv_decode_pkg::mul_op_t dx_mulop_o,
	output rv_decode_pkg::bcond_t dx_branchcond_o,
	output logic dx_jump_is_regoffs_o,
	output logic dx_result_is_linkaddr_o,
	output rv_decode_pkg::except_t dx_except_o,
	output rv_decode_pkg::addr_t dx_jump_target_o,
	output rv_decode_pkg::addr_t dx_pc_o,
	output rv_decode_pkg::addr_t dx_mispredict_addr_o
);
	import rv_decode_pkg::*;

	logic bubble;
	logic squash;

	assign bubble = d_stall_i || flush_d_x_i;
	// Either case kills every side effect of the instruction
	assign squash = bubble || dctrl.invalid;

	// ====================
	// Control register
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_rs1_o <= '0;
			dx_rs2_o <= '0;
			dx_rd_o <= '0;
			dx_alusrc_a_o <= ALUSRCA_RS1;
			dx_alusrc_b_o <= ALUSRCB_RS2;
			dx_aluop_o <= ALUOP_ADD;
			dx_memop_o <= MEMOP_NONE;
			dx_mulop_o <= MULOP_MUL;
			dx_branchcond_o <= BCOND_NEVER;
			dx_jump_is_regoffs_o <= 1'b0;
			dx_result_is_linkaddr_o <= 1'b0;
			dx_except_o <= EXCEPT_NONE;
		end else if (!x_stall_i) begin
			// Cleared sources stop a bubble from raising spurious RAW stalls in X
			dx_rs1_o <= squash ? '0 : dctrl.rs1;
			dx_rs2_o <= squash ? '0 : dctrl.rs2;
			dx_rd_o <= squash ? '0 : dctrl.rd;
			dx_memop_o <= squash ? MEMOP_NONE : dctrl.mem_op;
			dx_branchcond_o <= squash ? BCOND_NEVER : dctrl.bcond;
			// Bubble wins over the illegal trap
			dx_except_o <= bubble ? EXCEPT_NONE :
				(dctrl.invalid ? EXCEPT_ILLEGAL : dctrl.except);
			// Never start a multiply for a squashed slot
			dx_aluop_o <= (EXTENSION_M && squash) ? ALUOP_ADD : dctrl.alu_op;
			// No side effects on their own
			dx_alusrc_a_o <= dctrl.alusrc_a;
			dx_alusrc_b_o <= dctrl.alusrc_b;
			dx_mulop_o <= dctrl.mul_op;
			dx_jump_is_regoffs_o <= dctrl.jump_is_regoffs;
			dx_result_is_linkaddr_o <= dctrl.result_is_linkaddr;
		end
	end

	// Address and immediate register
	always_ff @(posedge clk) begin
		if (!x_stall_i) begin
			dx_imm_o <= dctrl.imm;
			dx_jump_target_o <= jump_target_i;
			// Fall-through address for a wrongly predicted branch
			dx_mispredict_addr_o <= pc_next_i;
			// Late jump target goes straight to X so a trap never sees a stale PC
			dx_pc_o <= (flush_d_x_i && f_jump_now_i) ? f_jump_target_i : pc_i;
		end
	end

endmodule

`default_nettype wire

// File: source/rv_instr_decoder.sv
// ====================
// RV32I/M instruction decoder
// Expands immediates and maps the opcode table onto execute controls
// Unknown opcodes, and M opcodes without the M extension, raise invalid
// ====================
`timescale 1ns/100ps
`default_nettype none

module rv_instr_decoder #(
	parameter bit EXTENSION_M = 1'b1
) (
	input wire rv_decode_pkg::instr_t instr_i,
	rv_dctrl_if.decoder dctrl
);
	import rv_decode_pkg::*;

	data_t imm_i;
	data_t imm_s;
	data_t imm_b;
	data_t imm_u;
	data_t imm_j;
	alu_op_t alu_f3;
	mem_op_t mem_f3;

	// Immediate formats, all sign extended from bit 31
	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// ALU op from funct3
	// SUB only for the register form (opcode bit 5), bit 30 picks SRA
	always_comb begin
		case (instr_i[14:12])
			3'b000: alu_f3 = (instr_i[5] && instr_i[30]) ? ALUOP_SUB : ALUOP_ADD;
			3'b001: alu_f3 = ALUOP_SLL;
			3'b010: alu_f3 = ALUOP_LT;
			3'b011: alu_f3 = ALUOP_LTU;
			3'b100: alu_f3 = ALUOP_XOR;
			3'b101: alu_f3 = instr_i[30] ? ALUOP_SRA : ALUOP_SRL;
			3'b110: alu_f3 = ALUOP_OR;
			default: alu_f3 = ALUOP_AND;
		endcase
	end

	// Memory op from funct3, opcode bit 5 separates stores from loads
	always_comb begin
		case ({instr_i[5], instr_i[14:12]})
			4'b0000: mem_f3 = MEMOP_LB;
			4'b0001: mem_f3 = MEMOP_LH;
			4'b0010: mem_f3 = MEMOP_LW;
			4'b0100: mem_f3 = MEMOP_LBU;
			4'b0101: mem_f3 = MEMOP_LHU;
			4'b1000: mem_f3 = MEMOP_SB;
			4'b1001: mem_f3 = MEMOP_SH;
			4'b1010: mem_f3 = MEMOP_SW;
			default: mem_f3 = MEMOP_NONE;
		endcase
	end

	// ====================
	// Opcode table
	// ====================
	always_comb begin
		// Defaults, register fields straight from the word
		dctrl.rs1 = instr_i[19:15];
		dctrl.rs2 = instr_i[24:20];
		dctrl.rd = instr_i[11:7];
		dctrl.imm = imm_i;
		dctrl.alusrc_a = ALUSRCA_RS1;
		dctrl.alusrc_b = ALUSRCB_RS2;
		dctrl.alu_op = ALUOP_ADD;
		dctrl.mem_op = MEMOP_NONE;
		dctrl.mul_op = MULOP_MUL;
		dctrl.bcond = BCOND_NEVER;
		dctrl.jump_is_regoffs = 1'b0;
		dctrl.result_is_linkaddr = 1'b0;
		dctrl.except = EXCEPT_NONE;
		dctrl.invalid = 1'b0;
		casez (instr_i)
			RV_BEQ, RV_BNE, RV_BLT, RV_BGE, RV_BLTU, RV_BGEU: begin
				// EQ/NE compare by SUB, the others by set-less-than
				dctrl.rd = '0;
				dctrl.imm = imm_b;
				dctrl.alu_op = !instr_i[14] ? ALUOP_SUB : (instr_i[13] ? ALUOP_LTU : ALUOP_LT);
				dctrl.bcond = (instr_i[12] ^ instr_i[14]) ? BCOND_NZERO : BCOND_ZERO;
			end
			RV_JALR: begin
				dctrl.rs2 = '0;
				dctrl.alusrc_b = ALUSRCB_IMM;
				dctrl.bcond = BCOND_ALWAYS;
				dctrl.jump_is_regoffs = 1'b1;
				dctrl.result_is_linkaddr = 1'b1;
			end
			RV_JAL: begin
				// Jump already taken in decode, X only writes the link
				dctrl.rs1 = '0;
				dctrl.rs2 = '0;
				dctrl.imm = imm_j;
				dctrl.result_is_linkaddr = 1'b1;
			end
			RV_LUI, RV_AUIPC: begin
				dctrl.rs1 = '0;
				dctrl.rs2 = '0;
				dctrl.imm = imm_u;
				dctrl.alusrc_b = ALUSRCB_IMM;
				// AUIPC adds to PC, LUI adds to x0
				dctrl.alusrc_a = instr_i[5] ? ALUSRCA_RS1 : ALUSRCA_PC;
			end
			RV_ADDI, RV_SLLI, RV_SLTI, RV_SLTIU, RV_XORI, RV_SRLI, RV_SRAI, RV_ORI, RV_ANDI: begin
				dctrl.rs2 = '0;
				dctrl.alusrc_b = ALUSRCB_IMM;
				dctrl.alu_op = alu_f3;
			end
			RV_ADD, RV_SUB, RV_SLL, RV_SLT, RV_SLTU, RV_XOR, RV_SRL, RV_SRA, RV_OR, RV_AND: begin
				dctrl.alu_op = alu_f3;
			end
			RV_LB, RV_LH, RV_LW, RV_LBU, RV_LHU: begin
				dctrl.rs2 = '0;
				dctrl.alusrc_b = ALUSRCB_IMM;
				dctrl.mem_op = mem_f3;
			end
			RV_SB, RV_SH, RV_SW: begin
				dctrl.rd = '0;
				dctrl.imm = imm_s;
				dctrl.alusrc_b = ALUSRCB_IMM;
				dctrl.mem_op = mem_f3;
			end
			RV_MUL, RV_MULH, RV_MULHSU, RV_MULHU, RV_DIV, RV_DIVU, RV_REM, RV_REMU: begin
				if (EXTENSION_M) begin
					dctrl.alu_op = ALUOP_MULDIV;
					dctrl.mul_op = mul_op_t'(instr_i[14:12]);
				end else begin
					dctrl.invalid = 1'b1;
				end
			end
			// Fences are NOPs on this core
			RV_FENCE, RV_FENCE_I: dctrl.rd = '0;
			RV_ECALL, RV_EBREAK, RV_MRET: begin
				dctrl.rs1 = '0;
				dctrl.rs2 = '0;
				dctrl.rd = '0;
				// Bit 29 marks MRET, bit 20 marks EBREAK
				dctrl.except = instr_i[29] ? EXCEPT_MRET :
					(instr_i[20] ? EXCEPT_EBREAK : EXCEPT_ECALL);
			end
			// CSR ops land here too
			default: dctrl.invalid = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: sources.f
source/rv_decode_pkg.sv
source/rv_dctrl_if.sv
source/rv_instr_decoder.sv
source/rv_branch_predict.sv
source/rv_decode_ctrl.sv
source/rv_dx_regs.sv
source/rv_decode_top.sv
tb/tb_rv_decode.sv

// File: tb/tb_rv_decode.sv
// ====================
// Directed testbench for the RV32 decode stage
// Encodes instructions from their field layouts and checks
// the D/X register, prediction, stall, bubble and CIR lock
// ====================
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decode;
	import rv_decode_pkg::*;

	logic clk;
	logic rst_n;
	instr_t fd_cir_i;
	logic fd_cir_vld_i;
	logic x_stall_i;
	logic flush_d_x_i;
	logic f_jump_rdy_i;
	logic f_jump_now_i;
	addr_t f_jump_target_i;
	wire df_cir_use_o;
	wire df_cir_lock_o;
	wire d_jump_req_o;
	addr_t d_jump_target_o;
	wire d_stall_o;
	regaddr_t d_rs1_o;
	regaddr_t d_rs2_o;
	regaddr_t dx_rs1_o;
	regaddr_t dx_rs2_o;
	regaddr_t dx_rd_o;
	data_t dx_imm_o;
	alusrc_a_t dx_alusrc_a_o;
	alusrc_b_t dx_alusrc_b_o;
	alu_op_t dx_aluop_o;
	mem_op_t dx_memop_o;
	mul_op_t dx_mulop_o;
	bcond_t dx_branchcond_o;
	wire dx_jump_is_regoffs_o;
	wire dx_result_is_linkaddr_o;
	except_t dx_except_o;
	addr_t dx_jump_target_o;
	addr_t dx_pc_o;
	addr_t dx_mispredict_addr_o;

	// Bookkeeping
	int seed = 18997;
	string test_name;
	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start;
	// PC model, advances by one word per accepted instruction
	addr_t exp_pc = 32'h0;
	addr_t accepted_pc;
	logic req_seen;
	addr_t target_seen;
	regaddr_t rs1_seen;
	regaddr_t rs2_seen;

	rv_decode_top #(
		.RESET_VECTOR(32'h0),
		.EXTENSION_M(1'b1)
	) rv_decode_top_i (
		.clk(clk), .rst_n(rst_n),
		.fd_cir_i(fd_cir_i), .fd_cir_vld_i(fd_cir_vld_i),
		.df_cir_use_o(df_cir_use_o), .df_cir_lock_o(df_cir_lock_o),
		.d_jump_req_o(d_jump_req_o), .d_jump_target_o(d_jump_target_o),
		.f_jump_rdy_i(f_jump_rdy_i), .f_jump_now_i(f_jump_now_i),
		.f_jump_target_i(f_jump_target_i),
		.d_stall_o(d_stall_o), .x_stall_i(x_stall_i), .flush_d_x_i(flush_d_x_i),
		.d_rs1_o(d_rs1_o), .d_rs2_o(d_rs2_o),
		.dx_rs1_o(dx_rs1_o), .dx_rs2_o(dx_rs2_o), .dx_rd_o(dx_rd_o),
		.dx_imm_o(dx_imm_o),
		.dx_alusrc_a_o(dx_alusrc_a_o), .dx_alusrc_b_o(dx_alusrc_b_o),
		.dx_aluop_o(dx_aluop_o), .dx_memop_o(dx_memop_o), .dx_mulop_o(dx_mulop_o),
		.dx_branchcond_o(dx_branchcond_o),
		.dx_jump_is_regoffs_o(dx_jump_is_regoffs_o),
		.dx_result_is_linkaddr_o(dx_result_is_linkaddr_o),
		.dx_except_o(dx_except_o), .dx_jump_target_o(dx_jump_target_o),
		.dx_pc_o(dx_pc_o), .dx_mispredict_addr_o(dx_mispredict_addr_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ====================
	// Encoders and helpers
	// ====================
	function automatic instr_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic instr_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	// B offset is 13 bits, bit 0 implied zero
	function automatic instr_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic data_t sext(logic [31:0] v, int bits);
		return (v[bits-1]) ? (v | (32'hffffffff << bits)) : v;
	endfunction

	// Never x0, so zeroed indices are visible
	function automatic regaddr_t rand_reg();
		return regaddr_t'({$random(seed)} % 31 + 1);
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		tests_run++;
	endtask

	task automatic end_test();
		if (error_count == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	// Waits at falling edges for the CIR use strobe
	// Records the prediction and the register read addresses
	task automatic wait_use();
		int n;
		n = 0;
		@(negedge clk);
		while (!df_cir_use_o && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!df_cir_use_o) begin
			error_count++;
			$display("Timeout in test %s: decode never accepted the instruction", test_name);
		end
		req_seen = d_jump_req_o;
		target_seen = d_jump_target_o;
		rs1_seen = d_rs1_o;
		rs2_seen = d_rs2_o;
	endtask

	task automatic note_accept();
		accepted_pc = exp_pc;
		exp_pc = exp_pc + 32'd4;
	endtask

	// One instruction through decode, dx checked at the falling edge after
	task automatic issue(input instr_t instr);
		@(posedge clk);
		fd_cir_i <= instr;
		fd_cir_vld_i <= 1'b1;
		wait_use();
		@(posedge clk);
		fd_cir_vld_i <= 1'b0;
		note_accept();
		@(negedge clk);
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset_alu();
		regaddr_t rd;
		regaddr_t rs1;
		logic [11:0] imm;
		logic [19:0] upper;
		addr_t first_pc;
		start_test("reset_alu");
		@(negedge clk);
		check_value("memop after reset", MEMOP_NONE, dx_memop_o);
		check_value("bcond after reset", BCOND_NEVER, dx_branchcond_o);
		check_value("except after reset", EXCEPT_NONE, dx_except_o);
		check_value("rd after reset", 0, dx_rd_o);
		rd = rand_reg();
		rs1 = rand_reg();
		imm = 12'($random(seed));
		issue(enc_i(imm, rs1, 3'b000, rd, 7'b0010011));
		check_value("addi aluop", ALUOP_ADD, dx_aluop_o);
		check_value("addi alusrc_b", ALUSRCB_IMM, dx_alusrc_b_o);
		check_value("addi imm", sext(imm, 12), dx_imm_o);
		check_value("addi rd", rd, dx_rd_o);
		check_value("addi rs1", rs1, dx_rs1_o);
		check_value("addi rs2", 0, dx_rs2_o);
		check_value("addi pc", accepted_pc, dx_pc_o);
		first_pc = accepted_pc;
		issue(enc_i(12'h001, rs1, 3'b000, rd, 7'b0010011));
		check_value("pc step", first_pc + 32'd4, dx_pc_o);
		// AUIPC takes the PC as first operand
		upper = 20'($random(seed));
		issue({upper, rd, 7'b0010111});
		check_value("auipc alusrc_a", ALUSRCA_PC, dx_alusrc_a_o);
		check_value("auipc imm", {upper, 12'h000}, dx_imm_o);
		end_test();
	endtask

	task automatic test_load_store();
		regaddr_t rd;
		regaddr_t rs1;
		regaddr_t rs2;
		logic [11:0] imm;
		start_test("load_store");
		rd = rand_reg();
		rs1 = rand_reg();
		imm = 12'($random(seed));
		issue(enc_i(imm, rs1, 3'b010, rd, 7'b0000011));
		check_value("lw memop", MEMOP_LW, dx_memop_o);
		check_value("lw imm", sext(imm, 12), dx_imm_o);
		check_value("lw rd", rd, dx_rd_o);
		check_value("lw alusrc_a", ALUSRCA_RS1, dx_alusrc_a_o);
		rs2 = rand_reg();
		imm = 12'($random(seed));
		issue(enc_s(imm, rs2, rs1, 3'b010));
		check_value("sw read rs1", rs1, rs1_seen);
		check_value("sw read rs2", rs2, rs2_seen);
		check_value("sw memop", MEMOP_SW, dx_memop_o);
		check_value("sw imm", sext(imm, 12), dx_imm_o);
		check_value("sw rd", 0, dx_rd_o);
		check_value("sw rs2", rs2, dx_rs2_o);
		end_test();
	endtask

	task automatic test_predict();
		logic [12:0] offs;
		addr_t target;
		start_test("predict");
		// Backward: sign bit set
		offs = {1'b1, 11'($random(seed)), 1'b0};
		issue(enc_b(offs, rand_reg(), rand_reg(), 3'b000));
		target = accepted_pc + sext(offs, 13);
		check_value("beq jump request", 1, req_seen);
		check_value("beq jump target", target, target_seen);
		check_value("beq dx target", target, dx_jump_target_o);
		check_value("beq bcond", BCOND_ZERO, dx_branchcond_o);
		check_value("beq mispredict addr", accepted_pc + 32'd4, dx_mispredict_addr_o);
		// JALR resolves in X, never predicted
		issue(enc_i(12'h7f0, rand_reg(), 3'b000, rand_reg(), 7'b1100111));
		check_value("jalr jump request", 0, req_seen);
		check_value("jalr regoffs", 1, dx_jump_is_regoffs_o);
		check_value("jalr bcond", BCOND_ALWAYS, dx_branchcond_o);
		offs = {1'b0, 11'($random(seed)), 1'b0};
		issue(enc_b(offs, rand_reg(), rand_reg(), 3'b001));
		check_value("bne jump request", 0, req_seen);
		check_value("bne bcond", BCOND_NZERO, dx_branchcond_o);
		check_value("bne regoffs", 0, dx_jump_is_regoffs_o);
		check_value("bne mispredict addr", accepted_pc + 32'd4, dx_mispredict_addr_o);
		end_test();
	endtask

	task automatic test_stall_bubble();
		regaddr_t rd_lw;
		regaddr_t rd_add;
		logic [11:0] imm;
		addr_t lw_pc;
		start_test("stall_bubble");
		rd_lw = rand_reg();
		rd_add = rand_reg();
		imm = 12'($random(seed));
		@(posedge clk);
		fd_cir_i <= enc_i(imm, rand_reg(), 3'b010, rd_lw, 7'b0000011);
		fd_cir_vld_i <= 1'b1;
		wait_use();
		// LW enters dx on this edge, X stalls from the next one
		@(posedge clk);
		x_stall_i <= 1'b1;
		fd_cir_i <= enc_i(12'h010, rand_reg(), 3'b000, rd_add, 7'b0010011);
		note_accept();
		lw_pc = accepted_pc;
		repeat (3) begin
			@(negedge clk);
			check_value("held memop", MEMOP_LW, dx_memop_o);
			check_value("held rd", rd_lw, dx_rd_o);
			check_value("held imm", sext(imm, 12), dx_imm_o);
			check_value("held pc", lw_pc, dx_pc_o);
			check_value("stall out", 1, d_stall_o);
			check_value("cir use", 0, df_cir_use_o);
		end
		@(posedge clk);
		x_stall_i <= 1'b0;
		wait_use();
		@(posedge clk);
		fd_cir_vld_i <= 1'b0;
		// Starved slots keep live words in the CIR that must not reach X
		fd_cir_i <= enc_i(imm, rand_reg(), 3'b010, rd_lw, 7'b0000011);
		note_accept();
		@(negedge clk);
		check_value("after stall rd", rd_add, dx_rd_o);
		check_value("after stall pc", accepted_pc, dx_pc_o);
		// Starved cycle becomes a bubble
		@(posedge clk);
		fd_cir_i <= enc_b(13'h010, rand_reg(), rand_reg(), 3'b001);
		@(negedge clk);
		check_value("bubble memop", MEMOP_NONE, dx_memop_o);
		check_value("bubble rd", 0, dx_rd_o);
		@(posedge clk);
		fd_cir_i <= 32'hffffffff;
		@(negedge clk);
		check_value("bubble bcond", BCOND_NEVER, dx_branchcond_o);
		@(posedge clk);
		@(negedge clk);
		check_value("bubble except", EXCEPT_NONE, dx_except_o);
		end_test();
	endtask

	task automatic test_ext_illegal();
		regaddr_t rd;
		start_test("ext_illegal");
		rd = rand_reg();
		issue({7'b0000001, rand_reg(), rand_reg(), 3'b000, rd, 7'b0110011});
		check_value("mul aluop", ALUOP_MULDIV, dx_aluop_o);
		check_value("mul mulop", MULOP_MUL, dx_mulop_o);
		check_value("mul rd", rd, dx_rd_o);
		issue({7'b0000001, rand_reg(), rand_reg(), 3'b101, rand_reg(), 7'b0110011});
		check_value("divu mulop", MULOP_DIVU, dx_mulop_o);
		// Opcode 1111111 is not in RV32IM
		issue({7'($random(seed)), rand_reg(), rand_reg(), 3'($random(seed)), rand_reg(),
			7'b1111111});
		check_value("illegal except", EXCEPT_ILLEGAL, dx_except_o);
		check_value("illegal rd", 0, dx_rd_o);
		issue(32'h00000073);
		check_value("ecall except", EXCEPT_ECALL, dx_except_o);
		end_test();
	endtask

	task automatic test_cir_lock();
		logic [20:0] offs;
		regaddr_t rd;
		addr_t target;
		int n;
		start_test("cir_lock");
		offs = {1'b1, 19'($random(seed)), 1'b0};
		rd = rand_reg();
		target = exp_pc + sext(offs, 21);
		// JAL while X holds and fetch is ready for the jump
		@(posedge clk);
		fd_cir_i <= enc_j(offs, rd);
		fd_cir_vld_i <= 1'b1;
		x_stall_i <= 1'b1;
		f_jump_target_i <= target;
		n = 0;
		@(negedge clk);
		while (!df_cir_lock_o && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!df_cir_lock_o) begin
			error_count++;
			$display("Timeout in test %s: CIR lock never asserted", test_name);
		end
		check_value("jal jump request", 1, d_jump_req_o);
		check_value("jal jump target", target, d_jump_target_o);
		repeat (3) begin
			@(negedge clk);
			check_value("lock held", 1, df_cir_lock_o);
			check_value("stall held", 1, d_stall_o);
		end
		@(posedge clk);
		x_stall_i <= 1'b0;
		wait_use();
		@(posedge clk);
		fd_cir_vld_i <= 1'b0;
		note_accept();
		// PC reloads from the fetch target as the lock releases
		exp_pc = target;
		@(negedge clk);
		check_value("lock released", 0, df_cir_lock_o);
		check_value("jal pc", accepted_pc, dx_pc_o);
		check_value("jal imm", sext(offs, 21), dx_imm_o);
		check_value("jal link", 1, dx_result_is_linkaddr_o);
		check_value("jal rd", rd, dx_rd_o);
		issue(enc_i(12'h004, rand_reg(), 3'b000, rand_reg(), 7'b0010011));
		check_value("pc after lock", target, dx_pc_o);
		end_test();
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		rst_n = 1'b0;
		fd_cir_i = '0;
		fd_cir_vld_i = 1'b0;
		x_stall_i = 1'b0;
		flush_d_x_i = 1'b0;
		f_jump_rdy_i = 1'b1;
		f_jump_now_i = 1'b0;
		f_jump_target_i = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_alu();
		test_load_store();
		test_predict();
		test_stall_bubble();
		test_ext_illegal();
		test_cir_lock();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
